/* files.f */
+incdir+tests
hw/feat_pkg.sv
hw/line_buffer.sv
hw/window_gather.sv
hw/window_bank.sv
hw/pixel_readout.sv
hw/feat_window_top.sv
tests/tb_feat_window.sv

/* hw/feat_pkg.sv */
package feat_pkg;

    // feature word and lane geometry
    localparam int WORD_W     = 32;
    localparam int PIX        = 4;

    // row storage
    localparam int LINE_DEPTH = 256;
    localparam int LINE_AW    = 8;

    // window storage per lane
    localparam int BANK_DEPTH = 64;
    localparam int BANK_AW    = 6;

    typedef logic [WORD_W-1:0] word_t;

    // PIX words side by side, lane 0 in the low bits
    typedef logic [PIX-1:0][WORD_W-1:0] pix_bus_t;

    // static layer settings, held for a whole row
    typedef struct packed {
        logic [7:0] iwidth;
        logic [3:0] k_w;
        logic [2:0] stride;
        logic [2:0] pad;
        logic [3:0] ci_group;
    } cfg_t;

    // one read per lane from the row RAM
    typedef struct packed {
        logic                          en;
        logic [PIX-1:0][LINE_AW-1:0]   addr;
    } line_rd_t;

    // all lanes written at one depth
    typedef struct packed {
        logic               en;
        logic [BANK_AW-1:0] addr;
        pix_bus_t           data;
    } bank_wr_t;

endpackage

/* hw/feat_window_top.sv */
`timescale 1ns/1ps

module feat_window_top (
    input  logic                         I_clk,
    input  logic                         rst_n,
    input  feat_pkg::cfg_t               cfg,
    input  logic                         ap_start,
    input  feat_pkg::word_t              feature,
    input  logic                         feature_dv,
    input  logic                         compute_en,
    input  logic                         rd_dv,
    input  logic [feat_pkg::BANK_AW-1:0] rd_depth,
    output logic                         window_ready,
    output feat_pkg::pix_bus_t           feature_out,
    output logic                         feature_out_dv
);
    import feat_pkg::*;

    line_rd_t           line_rd;
    pix_bus_t           line_data;
    bank_wr_t           bank_wr;
    logic [BANK_AW-1:0] bank_addr;
    pix_bus_t           bank_data;

    line_buffer u_line_buffer (
        .I_clk      (I_clk),
        .rst_n      (rst_n),
        .ap_start   (ap_start),
        .feature    (feature),
        .feature_dv (feature_dv),
        .rd_req     (line_rd),
        .rd_data    (line_data)
    );

    window_gather u_window_gather (
        .I_clk        (I_clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .ap_start     (ap_start),
        .compute_en   (compute_en),
        .rd_req       (line_rd),
        .rd_data      (line_data),
        .bank_wr      (bank_wr),
        .window_ready (window_ready)
    );

    window_bank u_window_bank (
        .I_clk   (I_clk),
        .wr      (bank_wr),
        .rd_addr (bank_addr),
        .rd_data (bank_data)
    );

    pixel_readout u_pixel_readout (
        .I_clk          (I_clk),
        .rst_n          (rst_n),
        .rd_dv          (rd_dv),
        .rd_depth       (rd_depth),
        .bank_addr      (bank_addr),
        .bank_data      (bank_data),
        .feature_out    (feature_out),
        .feature_out_dv (feature_out_dv)
    );

endmodule

/* hw/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
    input  logic               I_clk,
    input  logic               rst_n,
    input  logic               ap_start,
    input  feat_pkg::word_t    feature,
    input  logic               feature_dv,
    input  feat_pkg::line_rd_t rd_req,
    output feat_pkg::pix_bus_t rd_data
);
    import feat_pkg::*;

    word_t              mem [LINE_DEPTH];
    logic               wr_en_q;
    word_t              wr_data_q;
    logic [LINE_AW-1:0] wr_addr;

    // row write counter, restarts with each new row
    always_ff @(posedge I_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_en_q <= 1'b0;
            wr_addr <= '0;
        end
        else
        begin
            wr_en_q <= feature_dv;
            if (ap_start)
                wr_addr <= '0;
            else if (wr_en_q)
                wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge I_clk)
    begin
        wr_data_q <= feature;
        if (wr_en_q)
            mem[wr_addr] <= wr_data_q;
    end

    // one registered read port per lane on the same array
    always_ff @(posedge I_clk)
    begin
        if (rd_req.en)
        begin
            for (int p = 0; p < PIX; p++)
            begin
                rd_data[p] <= mem[rd_req.addr[p]];
            end
        end
    end

endmodule

/* hw/pixel_readout.sv */
`timescale 1ns/1ps

module pixel_readout (
    input  logic                         I_clk,
    input  logic                         rst_n,
    input  logic                         rd_dv,
    input  logic [feat_pkg::BANK_AW-1:0] rd_depth,
    output logic [feat_pkg::BANK_AW-1:0] bank_addr,
    input  feat_pkg::pix_bus_t           bank_data,
    output feat_pkg::pix_bus_t           feature_out,
    output logic                         feature_out_dv
);

    // strobe delayed to line up with the bank read data
    logic dv_q;

    assign bank_addr = rd_depth;

    always_ff @(posedge I_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dv_q           <= 1'b0;
            feature_out_dv <= 1'b0;
            feature_out    <= '0;
        end
        else
        begin
            dv_q           <= rd_dv;
            feature_out_dv <= dv_q;
            // hold the last window between reads
            if (dv_q)
                feature_out <= bank_data;
        end
    end

endmodule

/* hw/window_bank.sv */
`timescale 1ns/1ps

module window_bank (
    input  logic                         I_clk,
    input  feat_pkg::bank_wr_t           wr,
    input  logic [feat_pkg::BANK_AW-1:0] rd_addr,
    output feat_pkg::pix_bus_t           rd_data
);
    import feat_pkg::*;

    // one RAM per output lane
    word_t lane_mem [PIX][BANK_DEPTH];

    always_ff @(posedge I_clk)
    begin
        if (wr.en)
        begin
            for (int p = 0; p < PIX; p++)
            begin
                lane_mem[p][wr.addr] <= wr.data[p];
            end
        end
    end

    // separate read port, all lanes at the same depth
    always_ff @(posedge I_clk)
    begin
        for (int p = 0; p < PIX; p++)
        begin
            rd_data[p] <= lane_mem[p][rd_addr];
        end
    end

endmodule

/* hw/window_gather.sv */
`timescale 1ns/1ps

module window_gather (
    input  logic               I_clk,
    input  logic               rst_n,
    input  feat_pkg::cfg_t     cfg,
    input  logic               ap_start,
    input  logic               compute_en,
    output feat_pkg::line_rd_t rd_req,
    input  feat_pkg::pix_bus_t rd_data,
    output feat_pkg::bank_wr_t bank_wr,
    output logic               window_ready
);
    import feat_pkg::*;

    logic               busy;
    logic [LINE_AW-1:0] grp;
    logic [3:0]         tap;
    logic [3:0]         cig;
    logic [BANK_AW-1:0] step;
    logic               last_step;
    int                 src_col [PIX];
    logic [PIX-1:0]     in_range;

    // stage aligned with the line buffer read
    logic               req_en_q;
    logic               req_last_q;
    logic [BANK_AW-1:0] req_addr_q;
    logic [PIX-1:0]     req_mask_q;

    // stage driving the bank write
    logic               wr_en_q;
    logic               wr_last_q;
    logic [BANK_AW-1:0] wr_addr_q;
    pix_bus_t           wr_data_q;

    assign last_step = (tap == cfg.k_w - 4'd1) && (cig == cfg.ci_group - 4'd1);

    // step order is tap outer, channel group inner, so the bank depth just counts
    always_ff @(posedge I_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            grp  <= '0;
            tap  <= '0;
            cig  <= '0;
            step <= '0;
        end
        else if (ap_start)
        begin
            busy <= 1'b0;
            grp  <= '0;
        end
        else if (!busy)
        begin
            if (compute_en)
            begin
                busy <= 1'b1;
                tap  <= '0;
                cig  <= '0;
                step <= '0;
            end
        end
        else
        begin
            step <= step + 1'b1;
            if (cig == cfg.ci_group - 4'd1)
            begin
                cig <= '0;
                tap <= tap + 1'b1;
            end
            else
                cig <= cig + 1'b1;
            if (last_step)
            begin
                busy <= 1'b0;
                grp  <= grp + 1'b1;
            end
        end
    end

    // source column per lane, negative or past the row means padding
    always_comb
    begin
        rd_req.en = busy;
        for (int p = 0; p < PIX; p++)
        begin
            src_col[p] = (int'(grp) * PIX + p) * int'(cfg.stride) + int'(tap) - int'(cfg.pad);
            in_range[p] = (src_col[p] >= 0) && (src_col[p] < int'(cfg.iwidth));
            rd_req.addr[p] = LINE_AW'(src_col[p] * int'(cfg.ci_group) + int'(cig));
        end
    end

    always_ff @(posedge I_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_en_q     <= 1'b0;
            req_last_q   <= 1'b0;
            wr_en_q      <= 1'b0;
            wr_last_q    <= 1'b0;
            window_ready <= 1'b0;
        end
        else
        begin
            req_en_q     <= busy;
            req_last_q   <= busy && last_step;
            wr_en_q      <= req_en_q;
            wr_last_q    <= req_last_q;
            window_ready <= wr_last_q;
        end
    end

    always_ff @(posedge I_clk)
    begin
        req_addr_q <= step;
        req_mask_q <= in_range;
        wr_addr_q  <= req_addr_q;
        for (int p = 0; p < PIX; p++)
        begin
            wr_data_q[p] <= req_mask_q[p] ? rd_data[p] : '0;
        end
    end

    assign bank_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# build the testbench together with the RTL
verilator --binary --top-module tb_feat_window -f files.f

# run and keep the output for the verdict
sim_out="$(./obj_dir/Vtb_feat_window)"
echo "$sim_out"

if grep -qF -- '*** PASSED ***' <<< "$sim_out"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi

/* tests/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// copy of the row as written into the line buffer
word_t row_mem [LINE_DEPTH];

function automatic cfg_t make_cfg(input int iw, input int kw, input int st, input int pd,
                                  input int ci);
    cfg_t c;
    c.iwidth   = 8'(iw);
    c.k_w      = 4'(kw);
    c.stride   = 3'(st);
    c.pad      = 3'(pd);
    c.ci_group = 4'(ci);
    return c;
endfunction

// window of one bank depth for the given group, zero where the source column is padding
function automatic pix_bus_t expected_window(input int grp, input int depth);
    pix_bus_t w;
    int       tap;
    int       cg;
    int       col;
    tap = depth / int'(cfg.ci_group);
    cg  = depth % int'(cfg.ci_group);
    for (int p = 0; p < PIX; p++)
    begin
        col = (grp * PIX + p) * int'(cfg.stride) + tap - int'(cfg.pad);
        if (col >= 0 && col < int'(cfg.iwidth))
            w[p] = row_mem[col * int'(cfg.ci_group) + cg];
        else
            w[p] = '0;
    end
    return w;
endfunction

task automatic check_bus(input string name, input pix_bus_t exp_v, input pix_bus_t act_v);
    checks++;
    if (act_v !== exp_v)
    begin
        errors++;
        $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
endtask

task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v)
    begin
        errors++;
        $display("FAIL at %0t: %s expected %b, got %b", $time, name, exp_v, act_v);
    end
endtask

// new row: ap_start pulse, then iwidth * ci_group random words
task automatic load_row(input cfg_t c);
    int n;
    n = int'(c.iwidth) * int'(c.ci_group);
    @(negedge I_clk);
    cfg      = c;
    ap_start = 1'b1;
    @(negedge I_clk);
    ap_start = 1'b0;
    for (int i = 0; i < n; i++)
    begin
        feature     = $urandom();
        feature_dv  = 1'b1;
        row_mem[i]  = feature;
        @(negedge I_clk);
    end
    feature_dv = 1'b0;
    repeat (2) @(negedge I_clk);
endtask

// compute_en pulse, optionally repeated once while the fill is running
task automatic fill_group(input int grp, input bit repeat_pulse);
    int n;
    bit seen;
    @(negedge I_clk);
    compute_en = 1'b1;
    @(negedge I_clk);
    compute_en = repeat_pulse;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < FILL_LIMIT)
    begin
        @(negedge I_clk);
        compute_en = 1'b0;
        if (window_ready === 1'b1)
            seen = 1'b1;
        n++;
    end
    if (!seen)
    begin
        errors++;
        $display("fill of group %0d timed out, no window_ready within %0d cycles",
                 grp, FILL_LIMIT);
    end
endtask

// one read, data and strobe expected exactly two cycles later
task automatic read_window(input int grp, input int depth);
    @(negedge I_clk);
    rd_dv    = 1'b1;
    rd_depth = BANK_AW'(depth);
    @(negedge I_clk);
    rd_dv = 1'b0;
    check_bit("feature_out_dv", 1'b0, feature_out_dv);
    @(negedge I_clk);
    check_bit("feature_out_dv", 1'b1, feature_out_dv);
    check_bus("feature_out", expected_window(grp, depth), feature_out);
endtask

task automatic check_group(input int grp);
    for (int d = 0; d < int'(cfg.k_w) * int'(cfg.ci_group); d++)
    begin
        read_window(grp, d);
    end
endtask

`endif

/* tests/tb_feat_window.sv */
`timescale 1ns/1ps

module tb_feat_window;
    import feat_pkg::*;

    localparam int SEED        = 23267;
    localparam int CLK_PERIOD  = 10;
    localparam int FILL_LIMIT  = 64;
    // cycle budget of reset and the five tests
    localparam int TEST_CYCLES = 20 + 120 + 460 + 300 + 150;

    logic               I_clk;
    logic               rst_n;
    cfg_t               cfg;
    logic               ap_start;
    word_t              feature;
    logic               feature_dv;
    logic               compute_en;
    logic               rd_dv;
    logic [BANK_AW-1:0] rd_depth;
    logic               window_ready;
    pix_bus_t           feature_out;
    logic               feature_out_dv;
    int                 errors;
    int                 checks;

    `include "tb_model.svh"

    feat_window_top dut (
        .I_clk          (I_clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .ap_start       (ap_start),
        .feature        (feature),
        .feature_dv     (feature_dv),
        .compute_en     (compute_en),
        .rd_dv          (rd_dv),
        .rd_depth       (rd_depth),
        .window_ready   (window_ready),
        .feature_out    (feature_out),
        .feature_out_dv (feature_out_dv)
    );

    initial
    begin
        I_clk = 1'b0;
        forever #(CLK_PERIOD / 2) I_clk = ~I_clk;
    end

    initial
    begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish", TEST_CYCLES * 2);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic test_reset();
        check_bit("window_ready", 1'b0, window_ready);
        check_bit("feature_out_dv", 1'b0, feature_out_dv);
        check_bus("feature_out", '0, feature_out);
    endtask

    task automatic test_basic_window();
        load_row(make_cfg(16, 3, 1, 0, 2));
        fill_group(0, 1'b0);
        check_group(0);
    endtask

    // pad 2 with k_w 5 reaches past both ends of a 10 column row
    task automatic test_padding();
        // all 256 line words hold data, so a wrapped pad address reads nonzero
        load_row(make_cfg(128, 1, 1, 0, 2));
        load_row(make_cfg(10, 5, 1, 2, 1));
        for (int g = 0; g < 3; g++)
        begin
            fill_group(g, 1'b0);
            check_group(g);
        end
    endtask

    task automatic test_stride();
        load_row(make_cfg(24, 3, 2, 1, 2));
        fill_group(0, 1'b1);
        // an accepted second pulse would start another fill
        repeat (16)
        begin
            @(negedge I_clk);
            check_bit("window_ready", 1'b0, window_ready);
        end
        check_group(0);
        for (int g = 1; g < 3; g++)
        begin
            fill_group(g, 1'b0);
            check_group(g);
        end
    endtask

    task automatic test_restart();
        load_row(cfg);
        fill_group(0, 1'b0);
        check_group(0);
    endtask

    initial
    begin
        rst_n      = 1'b0;
        cfg        = '0;
        ap_start   = 1'b0;
        feature    = '0;
        feature_dv = 1'b0;
        compute_en = 1'b0;
        rd_dv      = 1'b0;
        rd_depth   = '0;
        errors     = 0;
        checks     = 0;
        void'($urandom(SEED));

        repeat (10) @(negedge I_clk);
        rst_n = 1'b1;
        @(negedge I_clk);

        test_reset();
        test_basic_window();
        test_padding();
        test_stride();
        test_restart();

        repeat (2) @(negedge I_clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
